// ==== sources.f ====
outrun_pkg.sv
pixel_cen.sv
video_timing.sv
sound_mailbox.sv
board_config.sv
status_dump.sv
outrun_shell.sv
tb_clock_gen.sv
tb_outrun_shell.sv

// ==== tb_outrun_shell.sv ====
// Testbench for the racing game board shell
// A cycle model of the shell is compared with the DUT on every falling edge
module tb_outrun_shell;

    localparam int H_TOTAL      = 16;
    localparam int H_ACTIVE     = 10;
    localparam int H_SYNC_START = 11;
    localparam int H_SYNC_END   = 13;
    localparam int V_TOTAL      = 8;
    localparam int V_ACTIVE     = 6;
    localparam int V_SYNC_START = 6;
    localparam int V_SYNC_END   = 7;

    // Game id, sound reset and video enable bits
    localparam logic [7:0] CFG_MASK = 8'b0001_0111;

    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL * 4;
    localparam int STIM_CYCLES  = 500;
    localparam int CYCLE_LIMIT  = 3 * FRAME_CYCLES + STIM_CYCLES + 200;

    logic        clk, rst_n;
    logic [15:0] dipsw;
    logic        main_wr, cfg_we, snd_rd, snd_wr;
    logic [7:0]  main_din, cfg_din, snd_din, st_addr;
    logic        pxl2_cen, pxl_cen, LHBL, LVBL, HS, VS, vint;
    logic        sndmap_pbf, snd_rstb;
    logic [7:0]  snd_dout, sndmap_dout, st_dout;

    // Model state
    int unsigned m_cnt, m_h, m_v;
    logic [7:0]  m_frame, m_cmd, m_reply, m_cfg, m_st;
    logic        m_pbf;
    logic [15:0] m_meta, m_sync;

    logic [31:0] lfsr      = 32'hc826;
    int unsigned cycles    = 0;
    int unsigned vint_seen = 0;

    tb_clock_gen #(.PERIOD(4), .RESET_CYCLES(8)) u_clk (.clk(clk), .rst_n(rst_n));

    outrun_shell #(
        .H_TOTAL(H_TOTAL), .H_ACTIVE(H_ACTIVE),
        .H_SYNC_START(H_SYNC_START), .H_SYNC_END(H_SYNC_END),
        .V_TOTAL(V_TOTAL), .V_ACTIVE(V_ACTIVE),
        .V_SYNC_START(V_SYNC_START), .V_SYNC_END(V_SYNC_END)
    ) UUT (.*);

    // Expected {LHBL, LVBL, HS, VS, vint} and status byte for the model state
    function automatic logic [12:0] ref_outputs(input logic [7:0] addr);
        logic [4:0] vid;
        logic [7:0] st;
        vid[4] = m_cfg[4] && (m_h < H_ACTIVE);
        vid[3] = m_cfg[4] && (m_v < V_ACTIVE);
        vid[2] = (m_h >= H_SYNC_START) && (m_h < H_SYNC_END);
        vid[1] = (m_v >= V_SYNC_START) && (m_v < V_SYNC_END);
        vid[0] = (m_cnt == 3) && (m_h == H_TOTAL - 1) && (m_v == V_ACTIVE - 1);
        st = 8'd0;
        case (addr[7:6])
            2'd0: st = addr[0] ? m_sync[15:8] : m_sync[7:0];
            2'd1: begin
                if (addr[5:0] == 6'd0) st = m_cmd;
                if (addr[5:0] == 6'd1) st = m_reply;
                if (addr[5:0] == 6'd2) st = {7'd0, m_pbf};
            end
            2'd2: st = (addr[5:0] == 6'd0) ? m_frame : 8'd0;
            default: begin
                if (addr[3:0] == 4'd0) st = m_reply;
                if (addr[3:0] == 4'd2) st = m_cfg;
            end
        endcase
        return {vid, st};
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, want);
            $display("Simulation failed");
            $fatal(1, "%s differs from the expected value", name);
        end
    endtask

    task automatic write_config(input logic [7:0] din);
        @(posedge clk);
        cfg_we  <= 1'b1;
        cfg_din <= din;
        @(posedge clk);
        cfg_we <= 1'b0;
    endtask

    task automatic read_status(input logic [7:0] addr, output logic [7:0] val);
        @(posedge clk);
        st_addr <= addr;
        @(posedge clk);
        @(negedge clk);
        val = st_dout;
    endtask

    // Model advances on the same edge as the DUT from the pre-edge inputs
    always @(posedge clk) begin : model_step
        logic [12:0] now;
        if (!rst_n) begin
            m_cnt   = 0;
            m_h     = 0;
            m_v     = 0;
            m_frame = 8'd0;
            m_cmd   = 8'd0;
            m_reply = 8'd0;
            m_pbf   = 1'b0;
            m_cfg   = 8'h10;
            m_st    = 8'd0;
            m_meta  = 16'd0;
            m_sync  = 16'd0;
        end else begin
            now = ref_outputs(st_addr);
            m_st = now[7:0];
            if (now[8]) m_frame = m_frame + 8'd1;
            if (m_cnt == 3) begin
                if (m_h == H_TOTAL - 1) begin
                    m_h = 0;
                    m_v = (m_v == V_TOTAL - 1) ? 0 : m_v + 1;
                end else begin
                    m_h = m_h + 1;
                end
            end
            m_cnt = (m_cnt + 1) % 4;
            if (main_wr) m_cmd = main_din;
            if (!m_cfg[2]) begin
                m_pbf   = 1'b0;
                m_reply = 8'd0;
            end else begin
                // Write wins over a read in the same cycle
                if (main_wr) m_pbf = 1'b1;
                else if (snd_rd) m_pbf = 1'b0;
                if (snd_wr) m_reply = snd_din;
            end
            if (cfg_we) m_cfg = cfg_din & CFG_MASK;
            m_sync = m_meta;
            m_meta = dipsw;
        end
    end

    always @(negedge clk) begin : compare
        logic [12:0] want;
        // Model state only exists from the first rising edge on
        if (cycles != 0) begin
            want = ref_outputs(st_addr);
            check_value("pxl2_cen", pxl2_cen, m_cnt % 2);
            check_value("pxl_cen", pxl_cen, m_cnt == 3);
            check_value("LHBL", LHBL, want[12]);
            check_value("LVBL", LVBL, want[11]);
            check_value("HS", HS, want[10]);
            check_value("VS", VS, want[9]);
            check_value("vint", vint, want[8]);
            check_value("snd_dout", snd_dout, m_cmd);
            check_value("sndmap_dout", sndmap_dout, m_reply);
            check_value("sndmap_pbf", sndmap_pbf, m_pbf);
            check_value("snd_rstb", snd_rstb, m_cfg[2]);
            check_value("st_dout", st_dout, m_st);
            if (want[8]) vint_seen = vint_seen + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $fatal(1, "cycle limit reached");
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [7:0]  val;
        dipsw    = '0;
        main_wr  = 1'b0;
        main_din = '0;
        cfg_we   = 1'b0;
        cfg_din  = '0;
        snd_rd   = 1'b0;
        snd_wr   = 1'b0;
        snd_din  = '0;
        st_addr  = '0;
        wait (rst_n);

        // Divider pattern counted from reset release
        for (int i = 1; i <= 12; i++) begin
            @(posedge clk);
            @(negedge clk);
            check_value("pxl2_cen", pxl2_cen, i % 2);
            check_value("pxl_cen", pxl_cen, (i % 4) == 3);
        end

        // Frame count read just after the first vint past two frames
        repeat (2 * FRAME_CYCLES) @(posedge clk);
        @(negedge clk);
        while (!vint) @(negedge clk);
        read_status(8'h80, val);
        check_value("frame_cnt", val, vint_seen);

        // Masked readback with video off and the sound CPU held in reset
        write_config(8'hEB);
        read_status(8'hC2, val);
        check_value("cfg_byte", val, 8'hEB & CFG_MASK);
        check_value("snd_rstb", snd_rstb, 1'b0);
        for (int i = 0; i < 64; i++) begin
            @(negedge clk);
            check_value("LHBL", LHBL, 1'b0);
            check_value("LVBL", LVBL, 1'b0);
        end
        write_config(8'h16);
        @(negedge clk);
        check_value("snd_rstb", snd_rstb, 1'b1);

        // Random mailbox traffic with exclusive sound side reads and writes
        for (int i = 0; i < 200; i++) begin
            take_bits(21, r);
            @(posedge clk);
            main_wr  <= r[0];
            snd_rd   <= (r[2:1] == 2'd1);
            snd_wr   <= (r[2:1] == 2'd2);
            main_din <= r[10:3];
            snd_din  <= r[18:11];
            st_addr  <= {6'b010000, r[20:19]};
        end
        @(posedge clk);
        main_wr  <= 1'b1;
        snd_rd   <= 1'b1;
        snd_wr   <= 1'b0;
        main_din <= 8'hA5;
        @(posedge clk);
        main_wr <= 1'b0;
        snd_rd  <= 1'b0;
        @(negedge clk);
        check_value("sndmap_pbf", sndmap_pbf, 1'b1);
        check_value("snd_dout", snd_dout, 8'hA5);

        // Sound CPU reset clears flag and reply only
        @(posedge clk);
        snd_wr  <= 1'b1;
        snd_din <= 8'h5A;
        @(posedge clk);
        snd_wr <= 1'b0;
        write_config(8'h12);
        @(posedge clk);
        @(negedge clk);
        check_value("sndmap_pbf", sndmap_pbf, 1'b0);
        check_value("sndmap_dout", sndmap_dout, 8'h00);
        check_value("snd_dout", snd_dout, 8'hA5);
        @(posedge clk);
        snd_wr  <= 1'b1;
        snd_din <= 8'h33;
        @(posedge clk);
        snd_wr <= 1'b0;
        @(negedge clk);
        check_value("sndmap_dout", sndmap_dout, 8'h00);
        write_config(8'h16);

        // DIP banks show on page 0 three cycles after the change
        for (int i = 0; i < 16; i++) begin
            take_bits(16, r);
            @(posedge clk);
            dipsw   <= r[15:0];
            st_addr <= 8'(i % 2);
            repeat (3) @(posedge clk);
            @(negedge clk);
            check_value("st_dout", st_dout, (i % 2) ? r[15:8] : r[7:0]);
        end

        repeat (4) @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== tb_clock_gen.sv ====
// Testbench clock and reset
// Free running clock and an active low reset held for a set number of cycles
module tb_clock_gen #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release away from the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== outrun_shell.sv ====
// Racing game board shell
// Clock enables, raster timing, sound mailbox, board configuration
// and the status dump
module outrun_shell
    import outrun_pkg::*;
#(
    parameter int H_TOTAL      = 512,
    parameter int H_ACTIVE     = 320,
    parameter int H_SYNC_START = 336,
    parameter int H_SYNC_END   = 368,
    parameter int V_TOTAL      = 262,
    parameter int V_ACTIVE     = 224,
    parameter int V_SYNC_START = 234,
    parameter int V_SYNC_END   = 237
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [2*BYTE_W-1:0]  dipsw,
    // Main CPU
    input  logic                 main_wr,
    input  logic [BYTE_W-1:0]    main_din,
    input  logic                 cfg_we,
    input  logic [BYTE_W-1:0]    cfg_din,
    // Sound CPU
    input  logic                 snd_rd,
    input  logic                 snd_wr,
    input  logic [BYTE_W-1:0]    snd_din,
    input  logic [ST_ADDR_W-1:0] st_addr,
    output logic                 pxl2_cen,
    output logic                 pxl_cen,
    output logic                 LHBL,
    output logic                 LVBL,
    output logic                 HS,
    output logic                 VS,
    output logic                 vint,
    output logic [BYTE_W-1:0]    snd_dout,
    output logic [BYTE_W-1:0]    sndmap_dout,
    output logic                 sndmap_pbf,
    output logic                 snd_rstb,
    output logic [BYTE_W-1:0]    st_dout
);

    logic              video_en;
    logic [BYTE_W-1:0] frame_cnt;
    logic [BYTE_W-1:0] cfg_byte;
    logic [BYTE_W-1:0] dip_a;
    logic [BYTE_W-1:0] dip_b;

    pixel_cen u_cen (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl2_cen ( pxl2_cen ),
        .pxl_cen  ( pxl_cen  )
    );

    video_timing #(
        .H_TOTAL      ( H_TOTAL      ),
        .H_ACTIVE     ( H_ACTIVE     ),
        .H_SYNC_START ( H_SYNC_START ),
        .H_SYNC_END   ( H_SYNC_END   ),
        .V_TOTAL      ( V_TOTAL      ),
        .V_ACTIVE     ( V_ACTIVE     ),
        .V_SYNC_START ( V_SYNC_START ),
        .V_SYNC_END   ( V_SYNC_END   )
    ) u_video (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .video_en  ( video_en  ),
        .LHBL      ( LHBL      ),
        .LVBL      ( LVBL      ),
        .HS        ( HS        ),
        .VS        ( VS        ),
        .vint      ( vint      ),
        .frame_cnt ( frame_cnt )
    );

    sound_mailbox u_mailbox (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .snd_rstb    ( snd_rstb    ),
        .main_wr     ( main_wr     ),
        .main_din    ( main_din    ),
        .snd_rd      ( snd_rd      ),
        .snd_wr      ( snd_wr      ),
        .snd_din     ( snd_din     ),
        .snd_dout    ( snd_dout    ),
        .sndmap_dout ( sndmap_dout ),
        .sndmap_pbf  ( sndmap_pbf  )
    );

    board_config u_config (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cfg_we   ( cfg_we   ),
        .cfg_din  ( cfg_din  ),
        .dipsw    ( dipsw    ),
        .cfg_byte ( cfg_byte ),
        .dip_a    ( dip_a    ),
        .dip_b    ( dip_b    ),
        .snd_rstb ( snd_rstb ),
        .video_en ( video_en )
    );

    status_dump u_status (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .st_addr     ( st_addr     ),
        .dip_a       ( dip_a       ),
        .dip_b       ( dip_b       ),
        .snd_dout    ( snd_dout    ),
        .sndmap_dout ( sndmap_dout ),
        .sndmap_pbf  ( sndmap_pbf  ),
        .frame_cnt   ( frame_cnt   ),
        .cfg_byte    ( cfg_byte    ),
        .st_dout     ( st_dout     )
    );

endmodule

// ==== status_dump.sv ====
// Paged status dump
// Registers one status byte per cycle, page picked by the top address bits
module status_dump
    import outrun_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [ST_ADDR_W-1:0] st_addr,
    input  logic [BYTE_W-1:0]    dip_a,
    input  logic [BYTE_W-1:0]    dip_b,
    input  logic [BYTE_W-1:0]    snd_dout,
    input  logic [BYTE_W-1:0]    sndmap_dout,
    input  logic                 sndmap_pbf,
    input  logic [BYTE_W-1:0]    frame_cnt,
    input  logic [BYTE_W-1:0]    cfg_byte,
    output logic [BYTE_W-1:0]    st_dout
);

    logic [1:0]           page;
    logic [ST_ADDR_W-3:0] low;
    logic [BYTE_W-1:0]    sel;

    assign page = st_addr[ST_ADDR_W-1 -: 2];
    assign low  = st_addr[ST_ADDR_W-3:0];

    always_comb begin
        sel = '0;
        case (page)
            ST_PAGE_DIP: begin
                sel = st_addr[0] ? dip_b : dip_a;
            end
            ST_PAGE_MAILBOX: begin
                case (low)
                    'd0:     sel = snd_dout;
                    'd1:     sel = sndmap_dout;
                    'd2:     sel = {{(BYTE_W-1){1'b0}}, sndmap_pbf};
                    default: sel = '0;
                endcase
            end
            ST_PAGE_VIDEO: begin
                sel = (low == '0) ? frame_cnt : '0;
            end
            ST_PAGE_BOARD: begin
                // Only the low nibble is decoded here
                case (st_addr[3:0])
                    4'd0:    sel = sndmap_dout;
                    4'd2:    sel = cfg_byte;
                    default: sel = '0;
                endcase
            end
            default: sel = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_dout <= '0;
        end else begin
            st_dout <= sel;
        end
    end

endmodule

// ==== board_config.sv ====
// Board configuration register and DIP switch sampling
// The main CPU writes the configuration byte; the DIP switch word is
// synchronized and split into two banks
module board_config
    import outrun_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cfg_we,
    input  logic [BYTE_W-1:0]   cfg_din,
    input  logic [2*BYTE_W-1:0] dipsw,
    output logic [BYTE_W-1:0]   cfg_byte,
    output logic [BYTE_W-1:0]   dip_a,
    output logic [BYTE_W-1:0]   dip_b,
    output logic                snd_rstb,
    output logic                video_en
);

    logic [2*BYTE_W-1:0] dip_meta;
    logic [2*BYTE_W-1:0] dip_sync;

    // Configuration register, unused bits never stored
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_byte <= CFG_RESET_VALUE;
        end else if (cfg_we) begin
            cfg_byte <= cfg_din & CFG_WRITE_MASK;
        end
    end

    assign snd_rstb = cfg_byte[CFG_SND_RSTB_BIT];
    assign video_en = cfg_byte[CFG_VIDEO_EN_BIT];

    // Two flop synchronizer on the switches
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dip_meta <= '0;
            dip_sync <= '0;
        end else begin
            dip_meta <= dipsw;
            dip_sync <= dip_meta;
        end
    end

    // Bank A is the low byte
    assign dip_a = dip_sync[BYTE_W-1:0];
    assign dip_b = dip_sync[2*BYTE_W-1:BYTE_W];

    // Reserved bits read back as zero whatever the CPU writes
    a_cfg_reserved: assert property (
        @(posedge clk) disable iff (!rst_n)
        (cfg_byte & ~CFG_WRITE_MASK) == '0
    ) else $error("reserved configuration bit set");

endmodule

// ==== sound_mailbox.sv ====
// Sound communication mailbox
// Command latch with a pending flag from the main CPU to the sound CPU,
// and a reply latch going back
module sound_mailbox
    import outrun_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              snd_rstb,
    // Main CPU side
    input  logic              main_wr,
    input  logic [BYTE_W-1:0] main_din,
    // Sound CPU side
    input  logic              snd_rd,
    input  logic              snd_wr,
    input  logic [BYTE_W-1:0] snd_din,
    output logic [BYTE_W-1:0] snd_dout,
    // Back to the main CPU
    output logic [BYTE_W-1:0] sndmap_dout,
    output logic              sndmap_pbf
);

    // Command latch, survives a sound CPU reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            snd_dout <= '0;
        end else if (main_wr) begin
            snd_dout <= main_din;
        end
    end

    // Pending byte flag
    // a write in the same cycle as a read keeps it set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sndmap_pbf <= 1'b0;
        end else if (!snd_rstb) begin
            sndmap_pbf <= 1'b0;
        end else if (main_wr) begin
            sndmap_pbf <= 1'b1;
        end else if (snd_rd) begin
            sndmap_pbf <= 1'b0;
        end
    end

    // Reply latch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sndmap_dout <= '0;
        end else if (!snd_rstb) begin
            sndmap_dout <= '0;
        end else if (snd_wr) begin
            sndmap_dout <= snd_din;
        end
    end

    // The sound CPU bus does one access at a time
    a_snd_rd_wr_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(snd_rd && snd_wr)
    ) else $error("snd_rd and snd_wr high together");

endmodule

// ==== video_timing.sv ====
// Raster timing generator
// Horizontal and vertical counters with blanking, sync, the vertical
// interrupt strobe and a frame counter
module video_timing
    import outrun_pkg::*;
#(
    parameter int H_TOTAL      = 512,
    parameter int H_ACTIVE     = 320,
    parameter int H_SYNC_START = 336,
    parameter int H_SYNC_END   = 368,
    parameter int V_TOTAL      = 262,
    parameter int V_ACTIVE     = 224,
    parameter int V_SYNC_START = 234,
    parameter int V_SYNC_END   = 237
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pxl_cen,
    input  logic              video_en,
    output logic              LHBL,
    output logic              LVBL,
    output logic              HS,
    output logic              VS,
    output logic              vint,
    output logic [BYTE_W-1:0] frame_cnt
);

    localparam int HW = $clog2(H_TOTAL);
    localparam int VW = $clog2(V_TOTAL);

    // Counter compare points at counter width
    localparam logic [HW-1:0] H_LAST = HW'(H_TOTAL - 1);
    localparam logic [HW-1:0] H_ACT  = HW'(H_ACTIVE);
    localparam logic [HW-1:0] H_SS   = HW'(H_SYNC_START);
    localparam logic [HW-1:0] H_SE   = HW'(H_SYNC_END);
    localparam logic [VW-1:0] V_LAST = VW'(V_TOTAL - 1);
    localparam logic [VW-1:0] V_ACT  = VW'(V_ACTIVE);
    localparam logic [VW-1:0] V_PRE  = VW'(V_ACTIVE - 1);
    localparam logic [VW-1:0] V_SS   = VW'(V_SYNC_START);
    localparam logic [VW-1:0] V_SE   = VW'(V_SYNC_END);

    logic [HW-1:0] hcount;
    logic [VW-1:0] vcount;
    logic          h_wrap;

    assign h_wrap = (hcount == H_LAST);

    // Raster position, moves once per pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcount <= '0;
            vcount <= '0;
        end else if (pxl_cen) begin
            if (h_wrap) begin
                hcount <= '0;
                if (vcount == V_LAST) begin
                    vcount <= '0;
                end else begin
                    vcount <= vcount + 1'b1;
                end
            end else begin
                hcount <= hcount + 1'b1;
            end
        end
    end

    // Blanking is active high while the beam is in the visible area
    assign LHBL = video_en && (hcount < H_ACT);
    assign LVBL = video_en && (vcount < V_ACT);

    assign HS = (hcount >= H_SS) && (hcount < H_SE);
    assign VS = (vcount >= V_SS) && (vcount < V_SE);

    // Strobe on the step into the first blanked line
    assign vint = pxl_cen && h_wrap && (vcount == V_PRE);

    // Frames seen since reset, wraps at 256
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_cnt <= '0;
        end else if (vint) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    // Interrupt only ever comes with a pixel step
    a_vint_on_cen: assert property (
        @(posedge clk) disable iff (!rst_n)
        vint |-> pxl_cen
    ) else $error("vint outside a pxl_cen cycle");

endmodule

// ==== pixel_cen.sv ====
// Pixel clock enable divider
// Makes the twice-pixel and pixel enables from the system clock
module pixel_cen
    import outrun_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    output logic pxl2_cen,
    output logic pxl_cen
);

    logic [CEN_CNT_W-1:0] cnt;

    // Free running divider
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Every other cycle
    assign pxl2_cen = cnt[0];

    // Once every four cycles, on the last count
    assign pxl_cen = (cnt == {CEN_CNT_W{1'b1}});

    // Pixel enable always lines up with a twice-pixel enable
    a_pxl_in_pxl2: assert property (
        @(posedge clk) disable iff (!rst_n)
        pxl_cen |-> pxl2_cen
    ) else $error("pxl_cen without pxl2_cen");

endmodule

// ==== outrun_pkg.sv ====
// Shared constants for the racing game board shell
// Byte widths, status page codes and the configuration byte layout
package outrun_pkg;

    // Data widths
    localparam int BYTE_W    = 8;
    localparam int ST_ADDR_W = 8;

    // Clock enable divider
    localparam int CEN_CNT_W = 2;

    // Status dump pages, picked by the top two address bits
    localparam logic [1:0] ST_PAGE_DIP     = 2'd0;
    localparam logic [1:0] ST_PAGE_MAILBOX = 2'd1;
    localparam logic [1:0] ST_PAGE_VIDEO   = 2'd2;
    localparam logic [1:0] ST_PAGE_BOARD   = 2'd3;

    // Configuration byte layout
    localparam int CFG_GAME_ID_LSB  = 0;
    localparam int CFG_SND_RSTB_BIT = 2;
    localparam int CFG_VIDEO_EN_BIT = 4;

    // Video on, sound CPU held in reset, game id zero
    localparam logic [BYTE_W-1:0] CFG_RESET_VALUE =
        BYTE_W'(1) << CFG_VIDEO_EN_BIT;

    // Only the game id, sound reset and video enable bits are stored
    localparam logic [BYTE_W-1:0] CFG_WRITE_MASK =
        (BYTE_W'(3) << CFG_GAME_ID_LSB)  |
        (BYTE_W'(1) << CFG_SND_RSTB_BIT) |
        (BYTE_W'(1) << CFG_VIDEO_EN_BIT);

endpackage
